//--- Bender.yml
package:
  name: brute_force_matcher

dependencies: {}

sources:
  - files:
      - hdl/matcher_cfg_pkg.sv
      - hdl/matcher_msg_pkg.sv
      - hdl/descriptor_dispatch.sv
      - hdl/model_descriptor_memory.sv
      - hdl/memory_read_arbiter.sv
      - hdl/match_engine.sv
      - hdl/brute_force_matcher.sv

  - target: simulation
    files:
      - tb/tb_brute_force_matcher.sv

//--- brute_force_matcher.f
hdl/matcher_cfg_pkg.sv
hdl/matcher_msg_pkg.sv
hdl/descriptor_dispatch.sv
hdl/model_descriptor_memory.sv
hdl/memory_read_arbiter.sv
hdl/match_engine.sv
hdl/brute_force_matcher.sv
tb/tb_brute_force_matcher.sv

//--- hdl/brute_force_matcher.sv
`timescale 1ns/1ns

module brute_force_matcher
    import matcher_cfg_pkg::*;
    import matcher_msg_pkg::*;
#(
    parameter int NUM_ENGINES = DEFAULT_NUM_ENGINES,
    parameter int MODEL_DEPTH = DEFAULT_MODEL_DEPTH
) (
    input  logic                   interface_clk,
    input  logic                   rst,
    input  logic                   i_load_valid,
    input  load_word_t             i_load_word,
    input  logic [NUM_ENGINES-1:0] i_match_ready,
    output logic                   o_load_ready,
    output logic [NUM_ENGINES-1:0] o_match_valid,
    output match_rec_t             o_match [NUM_ENGINES]
);

    // Dispatch side
    logic                   wr_en;
    model_addr_t            wr_addr;
    descriptor_t            wr_desc;
    logic [NUM_ENGINES-1:0] query_start;
    query_id_t              query_id;
    descriptor_t            query_desc;
    model_count_t           model_count;
    logic [NUM_ENGINES-1:0] engine_busy;

    // Shared read path
    logic [NUM_ENGINES-1:0] req;
    logic [NUM_ENGINES-1:0] ack;
    read_req_t              req_addr [NUM_ENGINES];
    model_addr_t            rd_addr;
    descriptor_t            rd_desc;
    descriptor_t            bus_desc;

    descriptor_dispatch #(
        .NUM_ENGINES (NUM_ENGINES),
        .MODEL_DEPTH (MODEL_DEPTH)
    ) u_dispatch (
        .interface_clk (interface_clk),
        .rst           (rst),
        .i_load_valid  (i_load_valid),
        .i_load_word   (i_load_word),
        .i_engine_busy (engine_busy),
        .o_load_ready  (o_load_ready),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_desc     (wr_desc),
        .o_query_start (query_start),
        .o_query_id    (query_id),
        .o_query_desc  (query_desc),
        .o_model_count (model_count)
    );

    model_descriptor_memory #(
        .MODEL_DEPTH (MODEL_DEPTH)
    ) u_memory (
        .interface_clk (interface_clk),
        .i_wr_en       (wr_en),
        .i_wr_addr     (wr_addr),
        .i_wr_desc     (wr_desc),
        .i_rd_addr     (rd_addr),
        .o_rd_desc     (rd_desc)
    );

    memory_read_arbiter #(
        .NUM_ENGINES (NUM_ENGINES)
    ) u_arbiter (
        .interface_clk (interface_clk),
        .rst           (rst),
        .i_req         (req),
        .i_req_addr    (req_addr),
        .i_rd_desc     (rd_desc),
        .o_ack         (ack),
        .o_rd_addr     (rd_addr),
        .o_desc        (bus_desc)
    );

    for (genvar i = 0; i < NUM_ENGINES; i++) begin : g_engine
        match_engine u_engine (
            .interface_clk (interface_clk),
            .rst           (rst),
            .i_query_start (query_start[i]),
            .i_query_id    (query_id),
            .i_query_desc  (query_desc),
            .i_model_count (model_count),
            .i_ack         (ack[i]),
            .i_desc        (bus_desc),
            .i_match_ready (i_match_ready[i]),
            .o_busy        (engine_busy[i]),
            .o_req         (req[i]),
            .o_req_addr    (req_addr[i]),
            .o_match_valid (o_match_valid[i]),
            .o_match       (o_match[i])
        );
    end

endmodule

//--- hdl/descriptor_dispatch.sv
`timescale 1ns/1ns

module descriptor_dispatch
    import matcher_cfg_pkg::*;
    import matcher_msg_pkg::*;
#(
    parameter int NUM_ENGINES = DEFAULT_NUM_ENGINES,
    parameter int MODEL_DEPTH = DEFAULT_MODEL_DEPTH
) (
    input  logic                   interface_clk,
    input  logic                   rst,
    input  logic                   i_load_valid,
    input  load_word_t             i_load_word,
    input  logic [NUM_ENGINES-1:0] i_engine_busy,
    output logic                   o_load_ready,
    output logic                   o_wr_en,
    output model_addr_t            o_wr_addr,
    output descriptor_t            o_wr_desc,
    output logic [NUM_ENGINES-1:0] o_query_start,
    output query_id_t              o_query_id,
    output descriptor_t            o_query_desc,
    output model_count_t           o_model_count
);

    localparam int PTR_WIDTH = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;
    localparam logic [PTR_WIDTH-1:0] LAST_PTR = PTR_WIDTH'(NUM_ENGINES - 1);
    localparam model_count_t FULL_COUNT = model_count_t'(MODEL_DEPTH);

    logic [PTR_WIDTH-1:0] engine_ptr;
    model_count_t         model_count;
    logic                 is_model;
    logic                 accept;

    assign is_model = (i_load_word.kind == MODEL);

    // A new model must not change the set under an active scan
    assign o_load_ready = is_model ? ~|i_engine_busy : ~i_engine_busy[engine_ptr];
    assign accept       = i_load_valid & o_load_ready;

    // Models past the depth are accepted and dropped
    assign o_wr_en   = accept & is_model & (model_count < FULL_COUNT);
    assign o_wr_addr = model_addr_t'(model_count);
    assign o_wr_desc = i_load_word.desc;

    // Query strobe to the engine under the pointer
    always_comb begin
        o_query_start = '0;
        if (accept && !is_model) begin
            o_query_start[engine_ptr] = 1'b1;
        end
    end

    assign o_query_id    = i_load_word.id;
    assign o_query_desc  = i_load_word.desc;
    assign o_model_count = model_count;

    always_ff @(posedge interface_clk) begin
        if (rst) begin
            model_count <= '0;
            engine_ptr  <= '0;
        end else begin
            if (o_wr_en) begin
                model_count <= model_count + 1'b1;
            end
            if (accept && !is_model) begin
                if (engine_ptr == LAST_PTR) begin
                    engine_ptr <= '0;
                end else begin
                    engine_ptr <= engine_ptr + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/match_engine.sv
`timescale 1ns/1ns

module match_engine
    import matcher_cfg_pkg::*;
    import matcher_msg_pkg::*;
(
    input  logic         interface_clk,
    input  logic         rst,
    input  logic         i_query_start,
    input  query_id_t    i_query_id,
    input  descriptor_t  i_query_desc,
    input  model_count_t i_model_count,
    input  logic         i_ack,
    input  descriptor_t  i_desc,
    input  logic         i_match_ready,
    output logic         o_busy,
    output logic         o_req,
    output read_req_t    o_req_addr,
    output logic         o_match_valid,
    output match_rec_t   o_match
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE,
        REPORT
    } eng_state_e;

    eng_state_e   state;
    query_id_t    query_id;
    descriptor_t  query_desc;
    model_count_t model_count;
    model_addr_t  model_addr;
    model_addr_t  best_index;
    distance_t    best_dist;
    distance_t    cur_dist;
    logic         last_model;

    // Population count of the differing bits
    function automatic distance_t hamming(input descriptor_t a, input descriptor_t b);
        descriptor_t diff;
        distance_t   ones;
        diff = a ^ b;
        ones = '0;
        for (int k = 0; k < DESC_WIDTH; k++) begin
            ones = ones + distance_t'(diff[k]);
        end
        return ones;
    endfunction

    assign cur_dist   = hamming(query_desc, i_desc);
    assign last_model = ((model_count_t'(model_addr) + 1'b1) == model_count);

    ////////////////////////////////////////////////////////////
    // Scan control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk) begin
        if (rst) begin
            state      <= IDLE;
            model_addr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_query_start) begin
                        model_addr <= '0;
                        state      <= (i_model_count == '0) ? REPORT : REQUEST;
                    end
                end
                REQUEST: begin
                    if (i_ack) begin
                        state <= RELEASE;
                    end
                end
                // Wait for ack low before the next request
                RELEASE: begin
                    if (!i_ack) begin
                        if (last_model) begin
                            state <= REPORT;
                        end else begin
                            model_addr <= model_addr + 1'b1;
                            state      <= REQUEST;
                        end
                    end
                end
                REPORT: begin
                    if (i_match_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Strict compare keeps the lower index on a tie
    always_ff @(posedge interface_clk) begin
        if (state == IDLE && i_query_start) begin
            query_id    <= i_query_id;
            query_desc  <= i_query_desc;
            model_count <= i_model_count;
            best_dist   <= NO_MODEL_DIST;
            best_index  <= '0;
        end else if (state == REQUEST && i_ack && cur_dist < best_dist) begin
            best_dist  <= cur_dist;
            best_index <= model_addr;
        end
    end

    assign o_busy        = (state != IDLE);
    assign o_req         = (state == REQUEST);
    assign o_req_addr    = '{addr: model_addr};
    assign o_match_valid = (state == REPORT);
    assign o_match       = '{id: query_id, index: best_index, distance: best_dist};

endmodule

//--- hdl/matcher_cfg_pkg.sv
package matcher_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // Sizing
    ////////////////////////////////////////////////////////////

    // Fixed by the binary keypoint format
    localparam int DESC_WIDTH = 64;

    // Defaults handed down by the top level
    localparam int DEFAULT_NUM_ENGINES = 2;
    localparam int DEFAULT_MODEL_DEPTH = 16;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    typedef logic [DESC_WIDTH-1:0] descriptor_t;
    typedef logic [3:0]            model_addr_t;
    typedef logic [4:0]            model_count_t;
    typedef logic [6:0]            distance_t;
    typedef logic [7:0]            query_id_t;

    // Reported when a query was searched against an empty model set
    localparam distance_t NO_MODEL_DIST = '1;

endpackage

//--- hdl/matcher_msg_pkg.sv
package matcher_msg_pkg;

    import matcher_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // Load port
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        MODEL = 1'b0,
        QUERY = 1'b1
    } load_kind_e;

    // Id only means something for QUERY words
    typedef struct packed {
        load_kind_e  kind;
        query_id_t   id;
        descriptor_t desc;
    } load_word_t;

    ////////////////////////////////////////////////////////////
    // Memory read request and match result
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        model_addr_t addr;
    } read_req_t;

    typedef struct packed {
        query_id_t   id;
        model_addr_t index;
        distance_t   distance;
    } match_rec_t;

endpackage

//--- hdl/memory_read_arbiter.sv
`timescale 1ns/1ns

module memory_read_arbiter
    import matcher_cfg_pkg::*;
    import matcher_msg_pkg::*;
#(
    parameter int NUM_ENGINES = DEFAULT_NUM_ENGINES
) (
    input  logic                   interface_clk,
    input  logic                   rst,
    input  logic [NUM_ENGINES-1:0] i_req,
    input  read_req_t              i_req_addr [NUM_ENGINES],
    input  descriptor_t            i_rd_desc,
    output logic [NUM_ENGINES-1:0] o_ack,
    output model_addr_t            o_rd_addr,
    output descriptor_t            o_desc
);

    localparam int SEL_WIDTH = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;
    localparam logic [SEL_WIDTH-1:0] LAST_SEL = SEL_WIDTH'(NUM_ENGINES - 1);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        ACK,
        RELEASE
    } arb_state_e;

    arb_state_e           state;
    logic [SEL_WIDTH-1:0] grant_sel;
    logic [SEL_WIDTH-1:0] prio_ptr;
    logic [SEL_WIDTH-1:0] next_sel;
    logic                 next_found;
    model_addr_t          rd_addr_q;

    // First requester at or after the priority pointer
    always_comb begin : pick_next
        int cand;
        next_sel   = '0;
        next_found = 1'b0;
        for (int off = 0; off < NUM_ENGINES; off++) begin
            cand = int'(prio_ptr) + off;
            if (cand >= NUM_ENGINES) begin
                cand = cand - NUM_ENGINES;
            end
            if (!next_found && i_req[cand]) begin
                next_found = 1'b1;
                next_sel   = SEL_WIDTH'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Four-phase sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge interface_clk) begin
        if (rst) begin
            state     <= IDLE;
            grant_sel <= '0;
            prio_ptr  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (next_found) begin
                        grant_sel <= next_sel;
                        prio_ptr  <= (next_sel == LAST_SEL) ? '0 : next_sel + 1'b1;
                        state     <= READ;
                    end
                end
                // Memory registers the address here
                READ:    state <= ACK;
                ACK: begin
                    if (!i_req[grant_sel]) begin
                        state <= RELEASE;
                    end
                end
                RELEASE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Address is held for the whole transfer
    always_ff @(posedge interface_clk) begin
        if (state == IDLE && next_found) begin
            rd_addr_q <= i_req_addr[next_sel].addr;
        end
    end

    always_comb begin
        o_ack = '0;
        if (state == ACK) begin
            o_ack[grant_sel] = 1'b1;
        end
    end

    assign o_rd_addr = rd_addr_q;
    assign o_desc    = i_rd_desc;

endmodule

//--- hdl/model_descriptor_memory.sv
`timescale 1ns/1ns

module model_descriptor_memory
    import matcher_cfg_pkg::*;
#(
    parameter int MODEL_DEPTH = DEFAULT_MODEL_DEPTH
) (
    input  logic        interface_clk,
    input  logic        i_wr_en,
    input  model_addr_t i_wr_addr,
    input  descriptor_t i_wr_desc,
    input  model_addr_t i_rd_addr,
    output descriptor_t o_rd_desc
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    descriptor_t mem [MODEL_DEPTH];

    always_ff @(posedge interface_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_desc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // One cycle from address to data
    always_ff @(posedge interface_clk) begin
        o_rd_desc <= mem[i_rd_addr];
    end

endmodule

//--- tb/matcher_tests.txt
# L kind(0 model, 1 query) id descriptor, all hex
# E engine id best_index distance, all hex
L 1 01 0000000000000000
E 0 01 0 7f
L 0 00 0000000000000000
L 0 00 ffffffffffffffff
L 0 00 00000000000000ff
L 0 00 ff00000000000000
L 0 00 0f0f0f0f0f0f0f0f
L 0 00 123456789abcdef0
L 0 00 00000000ffffffff
L 1 10 123456789abcdef0
E 1 10 5 00
L 1 11 000000000000000f
E 0 11 0 04
L 1 12 00000000000001ff
E 1 12 2 01
L 1 13 fffffffffffffffe
E 0 13 1 01
L 1 14 ff000000000000ff
E 1 14 2 08
L 1 15 0f0f0f0f0f0f0f0f
E 0 15 4 00
# second model batch extends the searched set
L 0 00 0000000000000001
L 0 00 8000000000000000
L 1 20 0000000000000003
E 1 20 7 01
L 1 21 8000000000000000
E 0 21 8 00
L 1 22 000000000000000f
E 1 22 7 03
L 1 23 123456789abcdef0
E 0 23 5 00

//--- tb/tb_brute_force_matcher.sv
`timescale 1ns/1ns

module tb_brute_force_matcher
    import matcher_cfg_pkg::*;
    import matcher_msg_pkg::*;
();

    localparam int NUM_ENGINES     = 2;
    localparam int MODEL_DEPTH     = 16;
    localparam int MAX_LOADS       = 64;
    localparam int MAX_EXPECT      = 32;
    localparam int CYCLES_PER_LINE = 200;

    logic                   interface_clk;
    logic                   rst;
    logic                   i_load_valid;
    load_word_t             i_load_word;
    logic [NUM_ENGINES-1:0] i_match_ready;
    logic                   o_load_ready;
    logic [NUM_ENGINES-1:0] o_match_valid;
    match_rec_t             o_match [NUM_ENGINES];

    // Test file contents
    load_word_t load_words [MAX_LOADS];
    match_rec_t exp_rec [NUM_ENGINES][MAX_EXPECT];
    int         exp_count [NUM_ENGINES];
    int         exp_seen [NUM_ENGINES];
    int         num_loads;
    int         num_lines;
    int         expected_total;
    int         matched_total;
    int         stall_cycles;
    int         cycle_count;
    int         timeout_limit;

    brute_force_matcher #(
        .NUM_ENGINES (NUM_ENGINES),
        .MODEL_DEPTH (MODEL_DEPTH)
    ) uut (
        .interface_clk (interface_clk),
        .rst           (rst),
        .i_load_valid  (i_load_valid),
        .i_load_word   (i_load_word),
        .i_match_ready (i_match_ready),
        .o_load_ready  (o_load_ready),
        .o_match_valid (o_match_valid),
        .o_match       (o_match)
    );

    initial begin
        interface_clk = 1'b0;
        forever #5 interface_clk = ~interface_clk;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
            fail_run("Output value differs from the test file");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test file parsing
    ////////////////////////////////////////////////////////////

    task automatic read_tests();
        int               fd;
        int               code;
        logic [31:0]      tag;
        logic [8*160-1:0] skip_line;
        logic [31:0]      f_a;
        logic [31:0]      f_b;
        logic [31:0]      f_c;
        logic [31:0]      f_d;
        logic [63:0]      f_desc;
        fd = $fopen("tb/matcher_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open tb/matcher_tests.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                if (tag == "#") begin
                    code = $fgets(skip_line, fd);
                end else if (tag == "L") begin
                    code = $fscanf(fd, "%h %h %h", f_a, f_b, f_desc);
                    if (code != 3 || num_loads >= MAX_LOADS) begin
                        fail_run("Bad or excess load line in the test file");
                    end
                    load_words[num_loads].kind = load_kind_e'(f_a[0]);
                    load_words[num_loads].id   = query_id_t'(f_b);
                    load_words[num_loads].desc = f_desc;
                    num_loads++;
                    num_lines++;
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d);
                    if (code != 4 || f_a >= NUM_ENGINES || exp_count[f_a] >= MAX_EXPECT) begin
                        fail_run("Bad or excess expectation line in the test file");
                    end
                    exp_rec[f_a][exp_count[f_a]] = '{id: query_id_t'(f_b),
                                                      index: model_addr_t'(f_c),
                                                      distance: distance_t'(f_d)};
                    exp_count[f_a]++;
                    expected_total++;
                    num_lines++;
                end else begin
                    fail_run("Unknown line tag in the test file");
                end
            end
        end
        $fclose(fd);
    endtask

    // Holds the word until the DUT accepts it, then moves to the next falling edge
    task automatic send_load(input load_word_t word);
        i_load_valid = 1'b1;
        i_load_word  = word;
        @(posedge interface_clk);
        while (!o_load_ready) begin
            stall_cycles++;
            @(posedge interface_clk);
        end
        @(negedge interface_clk);
    endtask

    task automatic take_record(input int e);
        match_rec_t want;
        if (exp_seen[e] >= exp_count[e]) begin
            fail_run($sformatf("Engine %0d sent a record that the test file does not list", e));
        end
        want = exp_rec[e][exp_seen[e]];
        check_value($sformatf("o_match[%0d].id", e), 64'(o_match[e].id), 64'(want.id));
        check_value($sformatf("o_match[%0d].index", e), 64'(o_match[e].index), 64'(want.index));
        check_value($sformatf("o_match[%0d].distance", e), 64'(o_match[e].distance),
                    64'(want.distance));
        exp_seen[e]++;
        matched_total++;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor, back-pressure and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge interface_clk) begin
        if (!rst) begin
            for (int e = 0; e < NUM_ENGINES; e++) begin
                if (o_match_valid[e] && i_match_ready[e]) begin
                    take_record(e);
                end
            end
        end
    end

    // Random ready per engine
    initial begin : drive_ready
        int unsigned seed;
        seed = 32'h11f2_0793;
        void'($urandom(seed));
        i_match_ready = '0;
        forever begin
            @(negedge interface_clk);
            if (rst) begin
                i_match_ready = '0;
            end else begin
                i_match_ready = NUM_ENGINES'($urandom);
            end
        end
    end

    always @(posedge interface_clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, %0d of %0d records seen",
                               cycle_count, matched_total, expected_total));
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : run_test
        rst           = 1'b1;
        i_load_valid  = 1'b0;
        i_load_word   = '0;
        read_tests();
        timeout_limit = num_lines * CYCLES_PER_LINE;
        repeat (16) @(posedge interface_clk);
        @(negedge interface_clk);
        rst = 1'b0;
        for (int n = 0; n < num_loads; n++) begin
            send_load(load_words[n]);
        end
        i_load_valid = 1'b0;
        while (matched_total < expected_total) begin
            @(negedge interface_clk);
        end
        @(negedge interface_clk);
        if (o_match_valid != '0) begin
            fail_run("An engine raised a record after all expected records were taken");
        end else if (stall_cycles == 0) begin
            fail_run("The load port never stalled on a busy engine");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
